/* control_defines.svh */
`ifndef CONTROL_DEFINES_SVH
`define CONTROL_DEFINES_SVH

// opcodes
`define OPC_RTYPE      6'h00
`define OPC_ADDI       6'h08
`define OPC_ADDIU      6'h09
`define OPC_BEQ        6'h04
`define OPC_BNE        6'h05
`define OPC_LW         6'h23
`define OPC_SW         6'h2b

// r-type funct field
`define FN_ADD         6'h20
`define FN_SUB         6'h22
`define FN_AND         6'h24
`define FN_SLT         6'h2a

// alu operations
`define ALU_LOAD       3'd0
`define ALU_ADD        3'd1
`define ALU_SUB        3'd2
`define ALU_AND        3'd3
`define ALU_CMP        3'd7

// alu operand selects
`define SRCA_PC        2'd0
`define SRCA_REG       2'd2
`define SRCB_REG       2'd0
`define SRCB_FOUR      2'd1
`define SRCB_IMM       2'd2
`define SRCB_BRANCH    2'd3

// register write-back selects
`define WB_ALU         3'd0
`define WB_MEM         3'd1
`define WB_CMP         3'd6
`define DST_RT         3'd0
`define DST_RD         3'd1

`define ADDR_PC        3'd0
`define ADDR_ALU       3'd4
`define PCSRC_ALU      2'd0
`define PCSRC_BRANCH   2'd2

// trap causes double as iorD vector selects
`define CAUSE_NONE     3'd0
`define CAUSE_ILLEGAL  3'd1
`define CAUSE_OVERFLOW 3'd3

`define STR_WORD       2'd1
`define MDR_WORD       2'd2
`define FLAG_LT        2'd0
`define FLAG_EQ        2'd2

`define MEM_WAIT_CYCLES 1 // 0 to 15

`endif

/* isa_pkg.sv */
package isaPkg;

	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	// what the execute sequence has to do for one instruction
	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opAnd,
		opSlt,
		opAddi,
		opAddiu,
		opBeq,
		opBne,
		opLw,
		opSw,
		opIllegal
	} opClassT;

endpackage

/* ctrl_pkg.sv */
package ctrlPkg;

	typedef enum logic [3:0] {
		sInit,
		sFetch,
		sPcInc,
		sIrLoad,
		sDecode,
		sExe0,
		sExe1,
		sMemAccess,
		sMemWait,
		sMemLoad,
		sWriteBack,
		sExcSave,   // trap cause onto iorD
		sExcEpc,
		sExcJump
	} seqStateT;

	typedef logic [2:0] aluOpT;
	typedef logic [2:0] wbSrcT;
	typedef logic [2:0] regDstT;
	typedef logic [2:0] addrSelT;
	typedef logic [1:0] srcSelT;
	typedef logic [1:0] pcSrcT;
	typedef logic [1:0] flagT;
	typedef logic [1:0] sizeT;
	typedef logic [2:0] causeT;
	typedef logic [3:0] waitCntT;

endpackage

/* ctrl_if.sv */
interface aluCtrlIf import ctrlPkg::*; ();
	aluOpT  aluOp;
	srcSelT aluSrcA;
	srcSelT aluSrcB;
	logic   abCtrl;
	logic   aluOutCtrl;
	flagT   flagCtrl;
	logic   compOp;

	modport ctrl (output aluOp, aluSrcA, aluSrcB, abCtrl, aluOutCtrl, flagCtrl, compOp);
	modport port (input aluOp, aluSrcA, aluSrcB, abCtrl, aluOutCtrl, flagCtrl, compOp);
endinterface

interface memCtrlIf import ctrlPkg::*; ();
	logic    wrMemo;
	addrSelT iorD;
	sizeT    strCtrl;
	sizeT    mdrCtrl;
	logic    mdrLoad;

	modport ctrl (output wrMemo, iorD, strCtrl, mdrCtrl, mdrLoad);
	modport port (input wrMemo, iorD, strCtrl, mdrCtrl, mdrLoad);
endinterface

// sequencer <-> write-back handshake for results and traps
interface resultIf import ctrlPkg::*; ();
	logic  wbStrobe;
	logic  trapReq;
	causeT trapCause;
	logic  trapDone;

	modport seq (output wbStrobe, trapDone, input trapReq, trapCause);
	modport wb (input wbStrobe, trapDone, output trapReq, trapCause);
endinterface

/* control_decode.sv */
`include "control_defines.svh"

module controlDecode
	import isaPkg::*;
(
	input  logic    clck,
	input  logic    rstN,
	input  logic    decStrobe,
	input  opcodeT  opCode,
	input  functT   funct,
	output opClassT opClass
);

	opClassT decoded;
	opClassT held;

	always_comb begin
		decoded = opIllegal; // anything not listed traps
		case (opCode)
			`OPC_RTYPE: begin
				case (funct)
					`FN_ADD: decoded = opAdd;
					`FN_SUB: decoded = opSub;
					`FN_AND: decoded = opAnd;
					`FN_SLT: decoded = opSlt;
					default: decoded = opIllegal;
				endcase
			end
			`OPC_ADDI:  decoded = opAddi;
			`OPC_ADDIU: decoded = opAddiu;
			`OPC_BEQ:   decoded = opBeq;
			`OPC_BNE:   decoded = opBne;
			`OPC_LW:    decoded = opLw;
			`OPC_SW:    decoded = opSw;
			default:    decoded = opIllegal;
		endcase
	end

	always_ff @(negedge clck) begin
		if (!rstN)
			held <= opIllegal;
		else if (decStrobe)
			held <= decoded;
	end

	// visible already in the decode cycle so the sequencer can branch on it
	assign opClass = decStrobe ? decoded : held;

endmodule

/* control_sequencer.sv */
`include "control_defines.svh"

module controlSequencer
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  logic    clck,
	input  logic    rstN,
	input  opClassT opClass,
	aluCtrlIf.ctrl  alu,
	memCtrlIf.ctrl  mem,
	resultIf.seq    res,
	output logic    pcWrite,
	output logic    pcWriteCond,
	output pcSrcT   pcSource,
	output logic    irWrite,
	output logic    epcWrite,
	output logic    dpReset,
	output logic    decStrobe
);

	seqStateT state;
	seqStateT nextState;
	waitCntT  waitCnt;
	logic     isBranch;
	logic     isImm;

	function automatic aluOpT aluOpFor(opClassT cls);
		case (cls)
			opSub:        return `ALU_SUB;
			opAnd:        return `ALU_AND;
			opSlt:        return `ALU_CMP;
			opBeq, opBne: return `ALU_CMP;
			default:      return `ALU_ADD; // add, addi(u), address calc
		endcase
	endfunction

	assign isBranch = (opClass == opBeq) || (opClass == opBne);
	assign isImm = (opClass == opAddi) || (opClass == opAddiu);

	assign decStrobe = state == sDecode;
	assign res.trapDone = state == sExcJump;
	// illegal opcodes are reported to write-back already in decode
	assign res.wbStrobe = (state == sWriteBack) || (state == sMemLoad)
		|| (decStrobe && opClass == opIllegal);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state

	always_comb begin
		nextState = sFetch;
		case (state)
			sInit:      nextState = sFetch;
			sFetch:     nextState = sPcInc;
			sPcInc:     nextState = sIrLoad;
			sIrLoad:    nextState = sDecode;
			sDecode:    nextState = res.trapReq ? sExcSave : sExe0;
			sExe0:      nextState = sExe1;
			sExe1: begin
				if (opClass == opLw || opClass == opSw)
					nextState = sMemAccess;
				else
					nextState = sWriteBack;
			end
			sMemAccess: begin
				if (opClass == opSw)
					nextState = sFetch;
				else if (`MEM_WAIT_CYCLES == 0)
					nextState = sMemLoad;
				else
					nextState = sMemWait;
			end
			sMemWait:   nextState = (waitCnt == waitCntT'(1)) ? sMemLoad : sMemWait;
			sMemLoad:   nextState = sWriteBack;
			sWriteBack: nextState = res.trapReq ? sExcSave : sFetch; // overflow
			sExcSave:   nextState = sExcEpc;
			sExcEpc:    nextState = sExcJump;
			default:    nextState = sFetch;
		endcase
	end

	always_ff @(negedge clck) begin
		if (!rstN)
			state <= sInit;
		else
			state <= nextState;
	end

	always_ff @(negedge clck) begin
		if (!rstN)
			waitCnt <= '0;
		else if (state == sMemAccess && opClass == opLw)
			waitCnt <= waitCntT'(`MEM_WAIT_CYCLES);
		else if (state == sMemWait)
			waitCnt <= waitCnt - 1'b1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registered control lines, inactive unless the state sets them

	always_ff @(negedge clck) begin
		alu.aluOp <= `ALU_LOAD;
		alu.aluSrcA <= `SRCA_PC;
		alu.aluSrcB <= `SRCB_REG;
		alu.abCtrl <= 1'b0;
		alu.aluOutCtrl <= 1'b0;
		alu.flagCtrl <= `FLAG_LT;
		alu.compOp <= 1'b0;
		mem.wrMemo <= 1'b0;
		mem.iorD <= `ADDR_PC;
		mem.strCtrl <= 2'd0;
		mem.mdrCtrl <= 2'd0;
		mem.mdrLoad <= 1'b0;
		pcWrite <= 1'b0;
		pcWriteCond <= 1'b0;
		pcSource <= `PCSRC_ALU;
		irWrite <= 1'b0;
		epcWrite <= 1'b0;
		dpReset <= 1'b0;
		if (rstN) begin
			case (state)
				sInit: dpReset <= 1'b1;
				sPcInc: begin
					alu.aluSrcB <= `SRCB_FOUR;
					alu.aluOp <= `ALU_ADD;
					pcWrite <= 1'b1;
				end
				sIrLoad: irWrite <= 1'b1;
				sExe0: begin
					alu.abCtrl <= 1'b1;
					if (isBranch) begin // branch target into aluOut
						alu.aluSrcB <= `SRCB_BRANCH;
						alu.aluOp <= `ALU_ADD;
						alu.aluOutCtrl <= 1'b1;
					end
				end
				sExe1: begin
					alu.aluSrcA <= `SRCA_REG;
					alu.aluOp <= aluOpFor(opClass);
					alu.aluOutCtrl <= !isBranch; // keep the target
					if (isImm)
						alu.aluSrcB <= `SRCB_IMM;
					else if (opClass == opLw || opClass == opSw)
						alu.aluSrcB <= `SRCB_BRANCH;
				end
				sWriteBack: begin
					if (isBranch) begin
						alu.aluSrcA <= `SRCA_REG;
						alu.aluOp <= `ALU_CMP;
						alu.flagCtrl <= `FLAG_EQ;
						alu.compOp <= opClass == opBne;
						pcWriteCond <= 1'b1;
						pcSource <= `PCSRC_BRANCH;
					end else if (opClass == opSlt) begin
						alu.aluSrcA <= `SRCA_REG;
						alu.aluOp <= `ALU_CMP;
						alu.flagCtrl <= `FLAG_LT;
					end
				end
				sMemAccess: begin
					mem.iorD <= `ADDR_ALU;
					if (opClass == opSw) begin
						mem.wrMemo <= 1'b1;
						mem.strCtrl <= `STR_WORD;
					end
				end
				sMemWait: mem.iorD <= `ADDR_ALU; // hold the address
				sMemLoad: begin
					mem.iorD <= `ADDR_ALU;
					mem.mdrLoad <= 1'b1;
					mem.mdrCtrl <= `MDR_WORD;
				end
				sExcSave: begin
					mem.iorD <= addrSelT'(res.trapCause); // handler vector by cause
					mem.mdrLoad <= 1'b1;
					mem.mdrCtrl <= `MDR_WORD;
				end
				sExcEpc: epcWrite <= 1'b1;
				sExcJump: begin
					pcWrite <= 1'b1;
					pcSource <= `PCSRC_ALU;
				end
				default: ;
			endcase
		end
	end

endmodule

/* write_back_control.sv */
`include "control_defines.svh"

module writeBackControl
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  logic    clck,
	input  logic    rstN,
	input  opClassT opClass,
	input  logic    overflow,
	resultIf.wb     res,
	output logic    regWrite,
	output regDstT  regDst,
	output wbSrcT   memToReg
);

	logic wbPrev;     // last cycle's strobe so a load writes on its second one
	logic ovfTrap;
	logic writesReg;

	assign ovfTrap = overflow && (opClass == opAdd || opClass == opSub || opClass == opAddi);
	assign writesReg = !(opClass inside {opBeq, opBne, opSw, opIllegal});
	assign res.trapReq = res.wbStrobe && (ovfTrap || opClass == opIllegal);

	always_ff @(negedge clck) begin
		regWrite <= 1'b0;
		regDst <= `DST_RT;
		memToReg <= `WB_ALU;
		if (!rstN) begin
			wbPrev <= 1'b0;
			res.trapCause <= `CAUSE_NONE;
		end else begin
			wbPrev <= res.wbStrobe;
			if (res.trapReq)
				res.trapCause <= ovfTrap ? `CAUSE_OVERFLOW : `CAUSE_ILLEGAL;
			else if (res.trapDone)
				res.trapCause <= `CAUSE_NONE;
			if (res.wbStrobe && writesReg && !res.trapReq) begin
				regWrite <= (opClass != opLw) || wbPrev;
				if (opClass inside {opAdd, opSub, opAnd, opSlt})
					regDst <= `DST_RD;
				if (opClass == opSlt)
					memToReg <= `WB_CMP;
				else if (opClass == opLw)
					memToReg <= `WB_MEM; // select settles during mdr load
			end
		end
	end

endmodule

/* control_unit.sv */
module controlUnit
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  logic    clck,
	input  logic    rstN,
	input  opcodeT  opCode,
	input  functT   funct,
	input  logic    overflow,
	output logic    pcWriteCond,
	output logic    pcWrite,
	output addrSelT iorD,
	output logic    wrMemo,
	output wbSrcT   memToReg,
	output logic    irWrite,
	output regDstT  regDst,
	output logic    regWrite,
	output logic    compOp,
	output flagT    flagCtrl,
	output logic    epcWrite,
	output sizeT    strCtrl,
	output sizeT    mdrCtrl,
	output logic    mdrLoad,
	output aluOpT   aluOp,
	output pcSrcT   pcSource,
	output srcSelT  aluSrcA,
	output srcSelT  aluSrcB,
	output logic    abCtrl,
	output logic    aluOutCtrl,
	output logic    dpReset
);

	opClassT opClass;
	logic    decStrobe;

	aluCtrlIf aluBus ();
	memCtrlIf memBus ();
	resultIf  resBus ();

	controlDecode uDecode (.clck, .rstN, .decStrobe, .opCode, .funct, .opClass);

	controlSequencer uSeq (
		.clck, .rstN, .opClass,
		.alu(aluBus.ctrl), .mem(memBus.ctrl), .res(resBus.seq),
		.pcWrite, .pcWriteCond, .pcSource, .irWrite, .epcWrite, .dpReset, .decStrobe
	);

	writeBackControl uWb (
		.clck, .rstN, .opClass, .overflow, .res(resBus.wb), .regWrite, .regDst, .memToReg
	);

	// flatten the buses onto the datapath pins
	assign aluOp = aluBus.aluOp;
	assign aluSrcA = aluBus.aluSrcA;
	assign aluSrcB = aluBus.aluSrcB;
	assign abCtrl = aluBus.abCtrl;
	assign aluOutCtrl = aluBus.aluOutCtrl;
	assign flagCtrl = aluBus.flagCtrl;
	assign compOp = aluBus.compOp;
	assign wrMemo = memBus.wrMemo;
	assign iorD = memBus.iorD;
	assign strCtrl = memBus.strCtrl;
	assign mdrCtrl = memBus.mdrCtrl;
	assign mdrLoad = memBus.mdrLoad;

endmodule

/* tb_clock_gen.sv */
module tbClockGen (
	output logic clck
);

	// period of 4 with rising edges at 2, 6, 10 ...
	initial begin
		clck = 1'b0;
		forever #2 clck = ~clck;
	end

endmodule

/* control_unit_sva.sv */
module controlUnitSva (
	input logic clck,
	input logic rstN,
	input logic pcWrite,
	input logic pcWriteCond,
	input logic regWrite,
	input logic epcWrite,
	input logic irWrite
);

	int failCount = 0; // assertion failures so far

	// outputs move on the falling edge, so sample on the rising one
	pcExclusive: assert property (@(posedge clck) disable iff (!rstN)
		!(pcWrite && pcWriteCond))
		else begin
			$error("pcWrite and pcWriteCond high in the same cycle");
			failCount++;
		end

	noWriteInTrap: assert property (@(posedge clck) disable iff (!rstN)
		!(regWrite && epcWrite))
		else begin
			$error("regWrite and epcWrite high in the same cycle");
			failCount++;
		end

	irSingleCycle: assert property (@(posedge clck) disable iff (!rstN)
		irWrite |=> !irWrite)
		else begin
			$error("irWrite held for more than one cycle");
			failCount++;
		end

endmodule

/* tb_control_unit.sv */
`include "control_defines.svh"

module tbControlUnit
	import isaPkg::*;
	import ctrlPkg::*;
();

	localparam int TIMEOUT_CYCLES = 400; // the tests need about 140 cycles after reset
	localparam int WINDOW_LIMIT = 32;    // longest instruction is lw with 15 wait states

	logic    clck;
	logic    rstN;
	opcodeT  opCode;
	functT   funct;
	logic    overflow;
	logic    pcWriteCond;
	logic    pcWrite;
	addrSelT iorD;
	logic    wrMemo;
	wbSrcT   memToReg;
	logic    irWrite;
	regDstT  regDst;
	logic    regWrite;
	logic    compOp;
	flagT    flagCtrl;
	logic    epcWrite;
	sizeT    strCtrl;
	sizeT    mdrCtrl;
	logic    mdrLoad;
	aluOpT   aluOp;
	pcSrcT   pcSource;
	srcSelT  aluSrcA;
	srcSelT  aluSrcB;
	logic    abCtrl;
	logic    aluOutCtrl;
	logic    dpReset;

	int valueErrors;
	int otherErrors;
	int cycleCount;
	int seed;
	opcodeT illegalOpc;

	// what one instruction did between two irWrite pulses
	int      period;
	int      regWriteCnt;
	int      regWriteAt;
	wbSrcT   wbSeen;
	regDstT  dstSeen;
	int      mdrLoadCnt;
	int      mdrLoadAt;
	addrSelT causeSeen;
	sizeT    mdrSeen;
	int      epcCnt;
	int      epcAt;
	int      pcWriteCnt;
	int      pcWriteAt;
	int      pcCondCnt;
	logic    compOpSeen;
	flagT    flagSeen;
	pcSrcT   pcSrcSeen;
	int      wrMemoCnt;
	sizeT    strSeen;
	aluOpT   aluOpSeen;
	srcSelT  srcBSeen;
	int      abCnt;

	tbClockGen uClk (.clck);

	controlUnit UUT (.*);

	bind controlUnit controlUnitSva uSva (
		.clck, .rstN, .pcWrite, .pcWriteCond, .regWrite, .epcWrite, .irWrite
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks

	task automatic checkCycles(input string name, input int exp, input int act);
		if (exp !== act) begin
			$display("ERR %s cycles: expected %0d, got %0d", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkCount(input string name, input string what, input int exp, input int act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %0d, got %0d", name, what, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkWbSrc(input string name, input wbSrcT exp, input wbSrcT act);
		if (exp !== act) begin
			$display("ERR %s memToReg: expected %0d, got %0d", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkRegDst(input string name, input regDstT exp, input regDstT act);
		if (exp !== act) begin
			$display("ERR %s regDst: expected %0d, got %0d", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkCause(input string name, input addrSelT exp, input addrSelT act);
		if (exp !== act) begin
			$display("ERR %s iorD: expected %0d, got %0d", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkAluOp(input string name, input aluOpT exp, input aluOpT act);
		if (exp !== act) begin
			$display("ERR %s aluOp: expected %0d, got %0d", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkSrcSel(input string name, input srcSelT exp, input srcSelT act);
		if (exp !== act) begin
			$display("ERR %s aluSrcB: expected %0d, got %0d", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkPcSrc(input string name, input pcSrcT exp, input pcSrcT act);
		if (exp !== act) begin
			$display("ERR %s pcSource: expected %0d, got %0d", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkFlag(input string name, input flagT exp, input flagT act);
		if (exp !== act) begin
			$display("ERR %s flagCtrl: expected %0d, got %0d", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkSize(input string name, input string what, input sizeT exp,
			input sizeT act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %0d, got %0d", name, what, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR %s compOp: expected %b, got %b", name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic checkOrder(input string name, input string what, input logic ok);
		if (!ok) begin
			$display("%s: %s", name, what);
			otherErrors++;
		end
	endtask

	task automatic printCounts();
		$display("errors: %0d value, %0d other, %0d assertion",
			valueErrors, otherErrors, UUT.uSva.failCount);
	endtask

	function automatic opcodeT randomIllegalOpcode();
		opcodeT opc;
		do begin
			opc = opcodeT'($random(seed));
		end while (opc inside {`OPC_RTYPE, `OPC_ADDI, `OPC_ADDIU, `OPC_BEQ, `OPC_BNE,
			`OPC_LW, `OPC_SW});
		return opc;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and observation

	// starts in the decode cycle and returns at the next irWrite
	task automatic runInstr(input opcodeT opc, input functT fn, input logic ovf);
		@(posedge clck);
		opCode <= opc;
		funct <= fn;
		overflow <= ovf;
		period = 0;
		regWriteCnt = 0;
		mdrLoadCnt = 0;
		epcCnt = 0;
		pcWriteCnt = 0;
		pcCondCnt = 0;
		wrMemoCnt = 0;
		abCnt = 0;
		aluOpSeen = `ALU_LOAD;
		do begin
			@(negedge clck);
			#1;
			period++;
			if (regWrite) begin
				regWriteCnt++;
				regWriteAt = period;
				wbSeen = memToReg;
				dstSeen = regDst;
			end
			if (mdrLoad) begin
				mdrLoadCnt++;
				mdrLoadAt = period;
				causeSeen = iorD;
				mdrSeen = mdrCtrl;
			end
			if (epcWrite) begin
				epcCnt++;
				epcAt = period;
			end
			if (pcWrite) begin
				if (pcWriteCnt == 0)
					pcWriteAt = period;
				pcWriteCnt++;
			end
			if (pcWriteCond) begin
				pcCondCnt++;
				compOpSeen = compOp;
				flagSeen = flagCtrl;
				pcSrcSeen = pcSource;
			end
			if (wrMemo) begin
				wrMemoCnt++;
				strSeen = strCtrl;
			end
			if (abCtrl)
				abCnt++;
			if (aluOutCtrl && aluSrcA == `SRCA_REG) begin // the sExe1 result latch
				aluOpSeen = aluOp;
				srcBSeen = aluSrcB;
			end
		end while (!irWrite && period < WINDOW_LIMIT);
		if (!irWrite) begin
			$display("no instruction register load within %0d cycles", WINDOW_LIMIT);
			otherErrors++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests

	task automatic resetTest();
		logic [34:0] idleBits;
		int waitCycles;
		repeat (5) @(posedge clck);
		idleBits = {pcWriteCond, pcWrite, iorD, wrMemo, memToReg, irWrite, regDst, regWrite,
			compOp, flagCtrl, epcWrite, strCtrl, mdrCtrl, mdrLoad, aluOp, pcSource,
			aluSrcA, aluSrcB, abCtrl, aluOutCtrl, dpReset};
		if (idleBits !== '0) begin
			$display("ERR reset outputs: expected %h, got %h", 35'h0, idleBits);
			valueErrors++;
		end
		rstN <= 1'b1;
		waitCycles = 0;
		do begin
			@(negedge clck);
			#1;
			waitCycles++;
		end while (!dpReset && waitCycles < 8);
		checkOrder("reset", "dpReset never pulsed after reset", dpReset);
		waitCycles = 0;
		do begin
			@(negedge clck);
			#1;
			waitCycles++;
			checkOrder("reset", "dpReset stayed high after its pulse", !dpReset);
		end while (!irWrite && waitCycles < 8);
		checkCycles("reset", 3, waitCycles);
	endtask

	task automatic testRType(input string name, input functT fn, input aluOpT expOp,
			input wbSrcT expSrc);
		runInstr(`OPC_RTYPE, fn, 1'b0);
		checkCycles(name, 7, period);
		checkCount(name, "regWrite pulses", 1, regWriteCnt);
		checkCount(name, "abCtrl pulses", 1, abCnt);
		checkRegDst(name, `DST_RD, dstSeen);
		checkWbSrc(name, expSrc, wbSeen);
		checkAluOp(name, expOp, aluOpSeen);
		checkSrcSel(name, `SRCB_REG, srcBSeen);
	endtask

	task automatic testImmediate(input string name, input opcodeT opc, input logic ovf);
		runInstr(opc, 6'h00, ovf);
		checkCycles(name, 7, period);
		checkCount(name, "regWrite pulses", 1, regWriteCnt);
		checkRegDst(name, `DST_RT, dstSeen);
		checkWbSrc(name, `WB_ALU, wbSeen);
		checkAluOp(name, `ALU_ADD, aluOpSeen);
		checkSrcSel(name, `SRCB_IMM, srcBSeen);
	endtask

	// overflow and unknown opcodes share the three trap states
	task automatic testTrap(input string name, input opcodeT opc, input functT fn,
			input logic ovf, input int expPeriod, input addrSelT expCause);
		runInstr(opc, fn, ovf);
		checkCycles(name, expPeriod, period);
		checkCount(name, "regWrite pulses", 0, regWriteCnt);
		checkCount(name, "mdrLoad pulses", 1, mdrLoadCnt);
		checkCause(name, expCause, causeSeen);
		checkCount(name, "epcWrite pulses", 1, epcCnt);
		checkCount(name, "pcWrite pulses", 2, pcWriteCnt); // handler jump plus next fetch
		checkOrder(name, "epcWrite did not follow the vector load", mdrLoadAt < epcAt);
		checkOrder(name, "handler jump did not follow epcWrite", epcAt < pcWriteAt);
	endtask

	task automatic testLoad();
		runInstr(`OPC_LW, 6'h00, 1'b0);
		checkCycles("lw", 9 + `MEM_WAIT_CYCLES, period);
		checkCount("lw", "mdrLoad pulses", 1, mdrLoadCnt);
		checkSize("lw", "mdrCtrl", `MDR_WORD, mdrSeen);
		checkCount("lw", "regWrite pulses", 1, regWriteCnt);
		checkWbSrc("lw", `WB_MEM, wbSeen);
		checkRegDst("lw", `DST_RT, dstSeen);
		checkSrcSel("lw", `SRCB_BRANCH, srcBSeen);
		checkOrder("lw", "register written before the data register load",
			mdrLoadAt < regWriteAt);
	endtask

	task automatic testStore();
		runInstr(`OPC_SW, 6'h00, 1'b0);
		checkCycles("sw", 7, period);
		checkCount("sw", "wrMemo pulses", 1, wrMemoCnt);
		checkSize("sw", "strCtrl", `STR_WORD, strSeen);
		checkCount("sw", "regWrite pulses", 0, regWriteCnt);
	endtask

	task automatic testBranch(input string name, input opcodeT opc, input logic expComp);
		runInstr(opc, 6'h00, 1'b0);
		checkCycles(name, 7, period);
		checkCount(name, "pcWriteCond pulses", 1, pcCondCnt);
		checkBit(name, expComp, compOpSeen);
		checkFlag(name, `FLAG_EQ, flagSeen);
		checkPcSrc(name, `PCSRC_BRANCH, pcSrcSeen);
		checkCount(name, "regWrite pulses", 0, regWriteCnt);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clck);
			cycleCount++;
		end
		$display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
		printCounts();
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		opCode = '0;
		funct = '0;
		overflow = 1'b0;
		valueErrors = 0;
		otherErrors = 0;
		seed = 86;
		resetTest();
		testRType("add", `FN_ADD, `ALU_ADD, `WB_ALU);
		testRType("sub", `FN_SUB, `ALU_SUB, `WB_ALU);
		testRType("and", `FN_AND, `ALU_AND, `WB_ALU);
		testRType("slt", `FN_SLT, `ALU_CMP, `WB_CMP);
		testTrap("addi overflow", `OPC_ADDI, 6'h00, 1'b1, 10, `CAUSE_OVERFLOW);
		testTrap("add overflow", `OPC_RTYPE, `FN_ADD, 1'b1, 10, `CAUSE_OVERFLOW);
		testImmediate("addiu overflow", `OPC_ADDIU, 1'b1); // unsigned form ignores it
		testImmediate("addi", `OPC_ADDI, 1'b0);
		testLoad();
		testStore();
		testBranch("beq", `OPC_BEQ, 1'b0);
		testBranch("bne", `OPC_BNE, 1'b1);
		testTrap("unknown funct", `OPC_RTYPE, 6'h3f, 1'b0, 7, `CAUSE_ILLEGAL);
		repeat (4) begin
			illegalOpc = randomIllegalOpcode();
			testTrap($sformatf("opcode %02h", illegalOpc), illegalOpc, 6'h00, 1'b0, 7,
				`CAUSE_ILLEGAL);
		end
		printCounts();
		if (valueErrors == 0 && otherErrors == 0 && UUT.uSva.failCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
ctrl_if.sv
control_decode.sv
control_sequencer.sv
write_back_control.sv
control_unit.sv
tb_clock_gen.sv
control_unit_sva.sv
tb_control_unit.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - ctrl_pkg.sv
      - ctrl_if.sv
      - control_decode.sv
      - control_sequencer.sv
      - write_back_control.sv
      - control_unit.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - control_unit_sva.sv
      - tb_control_unit.sv
